//--- bench/vseq_tb.sv
// Testbench for the vector issue subsystem with stimulus, assertions, reporting and timeout
`timescale 1ns/1ps
`default_nettype none

module vseq_tb import vseq_pkg::*; ();

  localparam int    ResetCycles   = 10;
  localparam int    MaxVl         = 63;
  // Slowest unit at full vl plus accept, take and response slack
  localparam int    OpCycles      = BaseLatMem + MaxVl + 12;
  // Ten instructions over six tests plus two slots for the idle waits
  localparam int    TimeoutCycles = ResetCycles + 12 * OpCycles;
  localparam elen_t AlignMask     = elen_t'((1 << AlignBits) - 1);

  logic    clk_i;
  logic    rst_ni;
  logic    req_valid_i;
  ara_op_e req_op_i;
  vreg_t   req_vs1_i, req_vs2_i, req_vd_i;
  vl_t     req_vl_i;
  elen_t   req_scalar_i;
  logic    req_ready_o, resp_valid_o, resp_error_o, idle_o;
  elen_t   resp_data_o;

  int      errors = 0;
  int      fails = 0;
  int      tests = 0;
  int      test_errs0 = 0;
  int      cycle = 0;
  int      last_resp_cycle = 0;
  int      raw_gap;
  integer  seed;
  string   waiting_for;
  logic    chk_reset, hold_chk, raw_chk, exp_sum, exp_err;
  elen_t   exp_data, rnd_val;
  vl_t     rnd_vl;

  vseq_top dut0 (
    .clk_i, .rst_ni, .req_valid_i, .req_op_i, .req_vs1_i, .req_vs2_i, .req_vd_i,
    .req_vl_i, .req_scalar_i, .req_ready_o, .resp_valid_o, .resp_error_o,
    .resp_data_o, .idle_o
  );

  always #10 clk_i = ~clk_i;

  // Cycle count for the timeout and the cycle of the latest response
  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (resp_valid_o) begin
      last_resp_cycle <= cycle;
    end
    if (cycle == TimeoutCycles) begin
      $display("Timeout after %0d cycles while waiting for %s", cycle, waiting_for);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Mismatch %s got %h expected %h at cycle %0d", sig, got, exp, cycle);
    errors++;
  endtask

  // Reset state of the dispatch port
  ready_after_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_reset |-> req_ready_o)
    else report_mismatch("req_ready_o", $sampled(req_ready_o), 1);
  idle_after_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_reset |-> idle_o)
    else report_mismatch("idle_o", $sampled(idle_o), 1);
  quiet_after_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_reset |-> !resp_valid_o)
    else report_mismatch("resp_valid_o", $sampled(resp_valid_o), 0);
  no_broadcast_after_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_reset |-> !dut0.pe_valid)
    else report_mismatch("pe_valid", $sampled(dut0.pe_valid), 0);

  // Every response is a single cycle
  resp_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |=> !resp_valid_o)
    else report_mismatch("resp_valid_o", $sampled(resp_valid_o), 0);
  // Scalar result is the scalar operand plus vl
  sum_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && exp_sum |-> resp_data_o == exp_data)
    else report_mismatch("resp_data_o", $sampled(resp_data_o), $sampled(exp_data));
  // Error only for a misaligned address
  resp_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> resp_error_o == exp_err)
    else report_mismatch("resp_error_o", $sampled(resp_error_o), $sampled(exp_err));
  // Consumer of a load result cannot answer before the load has run
  raw_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && raw_chk |-> (cycle - last_resp_cycle) >= raw_gap)
    else begin
      $display("VSUM answered too early, %0d cycles after the load ack instead of %0d",
               $sampled(cycle) - $sampled(last_resp_cycle), $sampled(raw_gap));
      errors++;
    end
  // A waiting request stays blocked while anything still runs
  blocked_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hold_chk && req_valid_i && !idle_o |-> !req_ready_o)
    else report_mismatch("req_ready_o", $sampled(req_ready_o), 0);
  store_after_load: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hold_chk && req_valid_i && req_ready_o && req_op_i == VSE |-> idle_o)
    else report_mismatch("idle_o", $sampled(idle_o), 1);

  // Inputs change 2 ns after the rising edge
  task automatic next_slot();
    @(posedge clk_i);
    #2;
  endtask

  task automatic dispatch(input ara_op_e op, input vreg_t vs1, input vreg_t vs2,
                          input vreg_t vd, input vl_t vl_a, input elen_t scalar);
    req_valid_i  = 1'b1;
    req_op_i     = op;
    req_vs1_i    = vs1;
    req_vs2_i    = vs2;
    req_vd_i     = vd;
    req_vl_i     = vl_a;
    req_scalar_i = scalar;
    waiting_for  = "request accept";
    // Ready is settled by mid cycle and the next edge takes the request
    @(negedge clk_i);
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    next_slot();
    req_valid_i = 1'b0;
  endtask

  task automatic wait_resp();
    waiting_for = "response";
    @(negedge clk_i);
    while (!resp_valid_o) begin
      @(negedge clk_i);
    end
    next_slot();
  endtask

  task automatic wait_idle();
    waiting_for = "idle";
    @(negedge clk_i);
    while (!idle_o) begin
      @(negedge clk_i);
    end
    next_slot();
  endtask

  task automatic run_sum(input vreg_t vs2, input vl_t vl_a, input elen_t scalar);
    exp_sum  = 1'b1;
    exp_err  = 1'b0;
    exp_data = scalar + elen_t'(vl_a);
    dispatch(VSUM, 5'd0, vs2, 5'd0, vl_a, scalar);
    wait_resp();
    exp_sum = 1'b0;
  endtask

  task automatic run_load(input vreg_t vd, input vl_t vl_a, input elen_t addr);
    exp_err = (addr & AlignMask) != '0;
    dispatch(VLE, 5'd0, 5'd0, vd, vl_a, addr);
    wait_resp();
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_errs0) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      fails++;
      $display("test %0d %s: %0d errors", tests, name, errors - test_errs0);
    end
    test_errs0 = errors;
  endtask

  initial begin
    seed         = 32'hbd82;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = VADD;
    req_vs1_i    = '0;
    req_vs2_i    = '0;
    req_vd_i     = '0;
    req_vl_i     = '0;
    req_scalar_i = '0;
    chk_reset    = 1'b0;
    hold_chk     = 1'b0;
    raw_chk      = 1'b0;
    exp_sum      = 1'b0;
    exp_err      = 1'b0;
    exp_data     = '0;
    raw_gap      = 0;
    waiting_for  = "reset";
    repeat (ResetCycles) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    next_slot();
    chk_reset = 1'b1;
    next_slot();
    chk_reset = 1'b0;
    end_test("after reset");

    rnd_vl  = vl_t'($random(seed));
    rnd_val = $random(seed);
    run_sum(5'd2, rnd_vl, rnd_val);
    wait_idle();
    end_test("vsum result");

    // Aligned base, then each of the two low address bits set
    rnd_val = $random(seed) & ~AlignMask;
    run_load(5'd8, vl_t'($random(seed)), rnd_val);
    run_load(5'd9, vl_t'($random(seed)), rnd_val | 32'h1);
    run_load(5'd10, vl_t'($random(seed)), rnd_val | 32'h2);
    wait_idle();
    end_test("vle address check");

    // Long load into v5, then a reduction of v5
    rnd_vl = vl_t'($random(seed)) | 6'h30;
    run_load(5'd5, rnd_vl, 32'h0000_1000);
    raw_gap = BaseLatMem + rnd_vl;
    raw_chk = 1'b1;
    run_sum(5'd5, vl_t'($random(seed)), $random(seed));
    raw_chk = 1'b0;
    wait_idle();
    end_test("read after write");

    hold_chk = 1'b1;
    exp_err  = 1'b0;
    dispatch(VLE, 5'd0, 5'd0, 5'd12, vl_t'($random(seed)), 32'h0000_2000);
    dispatch(VSE, 5'd12, 5'd0, 5'd0, vl_t'($random(seed)), 32'h0000_3000);
    wait_resp();
    wait_idle();
    hold_chk = 1'b0;
    end_test("structural hazard");

    // Second add reads the first one's destination
    hold_chk = 1'b1;
    dispatch(VADD, 5'd1, 5'd2, 5'd3, vl_t'($random(seed)), '0);
    dispatch(VADD, 5'd3, 5'd3, 5'd4, vl_t'($random(seed)), '0);
    wait_idle();
    hold_chk = 1'b0;
    end_test("back to back vadd");

    $display("tests run %0d, failed %0d, errors %0d", tests, fails, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- common/vseq_pkg.sv
// Sequencer localparams, operation and unit enums, id and register types, unit decode
`default_nettype none

package vseq_pkg;

  // Instructions in flight, one bit each in the running bitmap
  localparam int unsigned NrVInsn = 8;
  localparam int unsigned NrVReg  = 32;

  // Processing elements and their slot in the ready and done vectors
  localparam int unsigned NrPEs   = 3;
  localparam int unsigned PeAlu   = 0;
  localparam int unsigned PeLoad  = 1;
  localparam int unsigned PeStore = 2;

  // Unit latencies in cycles
  localparam int unsigned BaseLatAlu = 2;
  localparam int unsigned BaseLatMem = 4;
  localparam int unsigned AddrCycles = 2;

  // Low address bits that must be zero for an aligned access
  localparam int unsigned AlignBits = 2;

  // Countdown width, holds the largest base latency plus vl
  localparam int unsigned CntW = 8;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [$clog2(NrVReg)-1:0]  vreg_t;
  typedef logic [5:0]                 vl_t;
  typedef logic [31:0]                elen_t;

  // VADD writes vd from vs1 and vs2, VSUM reduces vs2 into a scalar
  // VLE writes vd, VSE stores vs1
  typedef enum logic [1:0] {
    VADD,
    VSUM,
    VLE,
    VSE
  } ara_op_e;

  typedef enum logic [1:0] {
    VFU_Alu,
    VFU_Load,
    VFU_Store
  } vfu_e;

  // Unit that executes an operation
  function automatic vfu_e vfu_of(ara_op_e op);
    case (op)
      VLE:     return VFU_Load;
      VSE:     return VFU_Store;
      default: return VFU_Alu;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- compile.f
common/vseq_pkg.sv
design/vinsn_tracker.sv
design/hazard_scoreboard.sv
design/issue_fsm.sv
design/exec_unit.sv
design/vseq_top.sv
bench/vseq_tb.sv

//--- design/exec_unit.sv
// Processing element with hazard wait, countdown, address check and scalar result
`timescale 1ns/1ps
`default_nettype none

module exec_unit import vseq_pkg::*; #(
  parameter vfu_e        Unit    = VFU_Alu,
  parameter int unsigned BaseLat = BaseLatAlu
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               pe_valid_i,
  input  wire vid_t               pe_id_i,
  input  wire ara_op_e            pe_op_i,
  input  wire vfu_e               pe_vfu_i,
  input  wire vl_t                pe_vl_i,
  input  wire elen_t              pe_scalar_i,
  input  wire logic [NrVInsn-1:0] pe_haz_i,
  input  wire logic [NrVInsn-1:0] running_i,
  output logic                    pe_ready_o,
  output logic [NrVInsn-1:0]      done_o,
  output logic                    addr_ack_o,
  output logic                    addr_err_o,
  output logic                    scalar_valid_o,
  output elen_t                   scalar_data_o
);

  // Load and store units own the address path
  localparam bit IsMem = (Unit != VFU_Alu);

  logic               take, finish;
  logic               busy_q, exec_q;
  logic [NrVInsn-1:0] haz_q, haz_live;
  logic [CntW-1:0]    cnt_q, addr_cnt_q;
  vid_t               id_q;
  ara_op_e            op_q;
  vl_t                vl_q;
  elen_t              scalar_q;

  assign take = pe_valid_i && (pe_vfu_i == Unit) && !busy_q;
  // Not ready while taking, so the next dispatch waits a cycle
  assign pe_ready_o = !busy_q && !take;

  // Dependencies drop out as they retire
  assign haz_live = haz_q & running_i;
  assign finish   = exec_q && (cnt_q == CntW'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      exec_q     <= 1'b0;
      haz_q      <= '0;
      cnt_q      <= '0;
      addr_cnt_q <= '0;
    end else begin
      if (take) begin
        busy_q <= 1'b1;
        exec_q <= 1'b0;
        haz_q  <= pe_haz_i & running_i;
      end else if (busy_q && !exec_q) begin
        haz_q <= haz_live;
        // All producers and readers gone, start the run
        if (haz_live == '0) begin
          exec_q <= 1'b1;
          cnt_q  <= CntW'(BaseLat) + CntW'(vl_q);
        end
      end else if (exec_q) begin
        cnt_q <= cnt_q - CntW'(1);
        if (finish) begin
          busy_q <= 1'b0;
          exec_q <= 1'b0;
        end
      end
      // Address phase runs from take, independent of hazards
      if (take && IsMem) begin
        addr_cnt_q <= CntW'(AddrCycles);
      end else if (addr_cnt_q != '0) begin
        addr_cnt_q <= addr_cnt_q - CntW'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      id_q     <= pe_id_i;
      op_q     <= pe_op_i;
      vl_q     <= pe_vl_i;
      scalar_q <= pe_scalar_i;
    end
  end

  assign done_o = finish ? (NrVInsn'(1) << id_q) : '0;

  // Scalar operand is the base address for loads and stores
  assign addr_ack_o = IsMem && (addr_cnt_q == CntW'(1));
  assign addr_err_o = addr_ack_o && (scalar_q[AlignBits-1:0] != '0);

  // Zero when not valid so the top can OR all units together
  assign scalar_valid_o = !IsMem && finish && (op_q == VSUM);
  assign scalar_data_o  = scalar_valid_o ? (scalar_q + elen_t'(vl_q)) : '0;

endmodule

`default_nettype wire

//--- design/hazard_scoreboard.sv
// Last reader and last writer per vector register, RAW, WAR and WAW hazard masks
`timescale 1ns/1ps
`default_nettype none

module hazard_scoreboard import vseq_pkg::*; (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               issue_i,
  input  wire vid_t               id_i,
  input  wire ara_op_e            op_i,
  input  wire vreg_t              vs1_i,
  input  wire vreg_t              vs2_i,
  input  wire vreg_t              vd_i,
  input  wire logic [NrVInsn-1:0] running_i,
  output logic [NrVInsn-1:0]      hazard_o
);

  vid_t [NrVReg-1:0]  rd_vid_q, wr_vid_q;
  logic [NrVReg-1:0]  rd_vld_q, rd_vld_d, wr_vld_q, wr_vld_d;
  logic [NrVReg-1:0]  rd_live, wr_live;
  logic               use_vs1, use_vs2, use_vd;
  logic [NrVInsn-1:0] raw_mask, war_mask, waw_mask;

  // Operands touched by each operation
  always_comb begin
    use_vs1 = 1'b0;
    use_vs2 = 1'b0;
    use_vd  = 1'b0;
    case (op_i)
      VADD: begin
        use_vs1 = 1'b1;
        use_vs2 = 1'b1;
        use_vd  = 1'b1;
      end
      VSUM:    use_vs2 = 1'b1;
      VLE:     use_vd  = 1'b1;
      VSE:     use_vs1 = 1'b1;
      default: use_vd  = 1'b0;
    endcase
  end

  // Entry counts only while its id still runs, so a reused id never aliases
  always_comb begin
    for (int v = 0; v < NrVReg; v++) begin
      rd_live[v] = rd_vld_q[v] & running_i[rd_vid_q[v]];
      wr_live[v] = wr_vld_q[v] & running_i[wr_vid_q[v]];
    end
  end

  always_comb begin
    raw_mask = '0;
    war_mask = '0;
    waw_mask = '0;
    // Sources wait for their producer
    if (use_vs1 && wr_live[vs1_i]) raw_mask[wr_vid_q[vs1_i]] = 1'b1;
    if (use_vs2 && wr_live[vs2_i]) raw_mask[wr_vid_q[vs2_i]] = 1'b1;
    // Destination waits for the last reader and the last writer
    if (use_vd && rd_live[vd_i]) war_mask[rd_vid_q[vd_i]] = 1'b1;
    if (use_vd && wr_live[vd_i]) waw_mask[wr_vid_q[vd_i]] = 1'b1;
  end

  assign hazard_o = raw_mask | war_mask | waw_mask;

  always_comb begin
    rd_vld_d = rd_live;
    wr_vld_d = wr_live;
    if (issue_i) begin
      if (use_vs1) rd_vld_d[vs1_i] = 1'b1;
      if (use_vs2) rd_vld_d[vs2_i] = 1'b1;
      if (use_vd)  wr_vld_d[vd_i]  = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_vld_q <= '0;
      wr_vld_q <= '0;
    end else begin
      rd_vld_q <= rd_vld_d;
      wr_vld_q <= wr_vld_d;
    end
  end

  // Id of the newest reader and writer, qualified by the valid bits above
  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      if (use_vs1) rd_vid_q[vs1_i] <= id_i;
      if (use_vs2) rd_vid_q[vs2_i] <= id_i;
      if (use_vd)  wr_vid_q[vd_i]  <= id_i;
    end
  end

  // The free id from the tracker is never listed as a live dependency
  no_self_hazard: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_i |-> !hazard_o[id_i]);

endmodule

`default_nettype wire

//--- design/issue_fsm.sv
// Issue FSM with structural-hazard check, registered broadcast and core response
`timescale 1ns/1ps
`default_nettype none

module issue_fsm import vseq_pkg::*; (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  // Dispatch from the core
  input  wire logic               req_valid_i,
  input  wire ara_op_e            req_op_i,
  input  wire vl_t                req_vl_i,
  input  wire elen_t              req_scalar_i,
  output logic                    req_ready_o,
  output logic                    resp_valid_o,
  output logic                    resp_error_o,
  output elen_t                   resp_data_o,
  // Resources
  input  wire logic [NrPEs-1:0]   pe_ready_i,
  input  wire vid_t               next_id_i,
  input  wire logic               full_i,
  input  wire logic               load_busy_i,
  input  wire logic               store_busy_i,
  input  wire logic [NrVInsn-1:0] hazard_i,
  // Answers from the units
  input  wire logic               addr_ack_i,
  input  wire logic               addr_err_i,
  input  wire logic               scalar_valid_i,
  input  wire elen_t              scalar_data_i,
  output logic                    issue_o,
  // Broadcast to the units
  output logic                    pe_valid_o,
  output vid_t                    pe_id_o,
  output ara_op_e                 pe_op_o,
  output vfu_e                    pe_vfu_o,
  output vl_t                     pe_vl_o,
  output elen_t                   pe_scalar_o,
  output logic [NrVInsn-1:0]      pe_haz_o
);

  typedef enum logic {
    IDLE,
    WAIT
  } state_e;

  state_e state_d, state_q;
  vfu_e   req_vfu;
  logic   struct_haz;

  assign req_vfu = vfu_of(req_op_i);

  // Load and store share the address path, neither starts while the other runs
  always_comb begin
    case (req_vfu)
      VFU_Load:  struct_haz = store_busy_i;
      VFU_Store: struct_haz = load_busy_i;
      default:   struct_haz = 1'b0;
    endcase
  end

  assign req_ready_o = (state_q == IDLE) && (&pe_ready_i) && !full_i && !struct_haz;
  assign issue_o     = req_valid_i && req_ready_o;

  always_comb begin
    state_d      = state_q;
    resp_valid_o = 1'b0;
    resp_error_o = 1'b0;
    resp_data_o  = '0;
    case (state_q)
      IDLE: begin
        // Everything but VADD answers the core before the next dispatch
        if (issue_o && (req_op_i != VADD)) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (pe_op_o == VSUM) begin
          if (scalar_valid_i) begin
            resp_valid_o = 1'b1;
            resp_data_o  = scalar_data_i;
            state_d      = IDLE;
          end
        end else if (addr_ack_i) begin
          resp_valid_o = 1'b1;
          resp_error_o = addr_err_i;
          state_d      = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      pe_valid_o <= 1'b0;
    end else begin
      state_q    <= state_d;
      pe_valid_o <= issue_o;
    end
  end

  // Broadcast payload, held after accept so WAIT still knows the op
  always_ff @(posedge clk_i) begin
    if (issue_o) begin
      pe_id_o     <= next_id_i;
      pe_op_o     <= req_op_i;
      pe_vfu_o    <= req_vfu;
      pe_vl_o     <= req_vl_i;
      pe_scalar_o <= req_scalar_i;
      pe_haz_o    <= hazard_i;
    end
  end

  // Unit answers only arrive while an answer is awaited, none is lost in IDLE
  resp_only_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == IDLE) |-> !(resp_valid_o || addr_ack_i || scalar_valid_i));

endmodule

`default_nettype wire

//--- design/vinsn_tracker.sv
// Running-instruction bitmaps per unit, lowest free id, full and idle flags, busy flags
`timescale 1ns/1ps
`default_nettype none

module vinsn_tracker import vseq_pkg::*; (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  // Accepted instruction and the unit it goes to
  input  wire logic               issue_i,
  input  wire vfu_e               issue_vfu_i,
  // One-hot done pulses
  input  wire logic [NrVInsn-1:0] done_alu_i,
  input  wire logic [NrVInsn-1:0] done_load_i,
  input  wire logic [NrVInsn-1:0] done_store_i,
  output logic [NrVInsn-1:0]      running_o,
  output vid_t                    next_id_o,
  output logic                    full_o,
  output logic                    idle_o,
  output logic                    load_busy_o,
  output logic                    store_busy_o
);

  logic [NrPEs-1:0][NrVInsn-1:0] pe_running_d, pe_running_q;
  logic [NrPEs-1:0][NrVInsn-1:0] pe_done;

  assign pe_done[PeAlu]   = done_alu_i;
  assign pe_done[PeLoad]  = done_load_i;
  assign pe_done[PeStore] = done_store_i;

  always_comb begin
    pe_running_d = pe_running_q;
    // Retire first, the free id never collides with a retiring one
    for (int unsigned pe = 0; pe < NrPEs; pe++) begin
      pe_running_d[pe] &= ~pe_done[pe];
    end
    if (issue_i) begin
      case (issue_vfu_i)
        VFU_Load:  pe_running_d[PeLoad][next_id_o]  = 1'b1;
        VFU_Store: pe_running_d[PeStore][next_id_o] = 1'b1;
        default:   pe_running_d[PeAlu][next_id_o]   = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_running_q <= '0;
    end else begin
      pe_running_q <= pe_running_d;
    end
  end

  // Instruction runs somewhere if any unit holds its bit
  always_comb begin
    running_o = '0;
    for (int unsigned pe = 0; pe < NrPEs; pe++) begin
      running_o |= pe_running_q[pe];
    end
  end

  // Scan downwards so the lowest clear bit is the last one kept
  always_comb begin
    next_id_o = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        next_id_o = vid_t'(i);
      end
    end
  end

  assign full_o       = &running_o;
  assign idle_o       = ~|running_o;
  assign load_busy_o  = |pe_running_q[PeLoad];
  assign store_busy_o = |pe_running_q[PeStore];

  // A unit only retires ids that were issued to that same unit
  done_targets_running: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pe_done & ~pe_running_q) == '0);

endmodule

`default_nettype wire

//--- design/vseq_top.sv
// Top level with tracker, scoreboard, issue FSM and the ALU, load and store units
`timescale 1ns/1ps
`default_nettype none

module vseq_top import vseq_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  input  wire logic    req_valid_i,
  input  wire ara_op_e req_op_i,
  input  wire vreg_t   req_vs1_i,
  input  wire vreg_t   req_vs2_i,
  input  wire vreg_t   req_vd_i,
  input  wire vl_t     req_vl_i,
  input  wire elen_t   req_scalar_i,
  output logic         req_ready_o,
  output logic         resp_valid_o,
  output logic         resp_error_o,
  output elen_t        resp_data_o,
  output logic         idle_o
);

  logic                          issue, full, load_busy, store_busy, pe_valid;
  logic [NrVInsn-1:0]            running, hazard, pe_haz;
  vid_t                          next_id, pe_id;
  ara_op_e                       pe_op;
  vfu_e                          pe_vfu;
  vl_t                           pe_vl;
  elen_t                         pe_scalar;
  logic [NrPEs-1:0]              pe_ready, addr_ack, addr_err, scalar_valid;
  logic [NrPEs-1:0][NrVInsn-1:0] pe_done;
  elen_t [NrPEs-1:0]             scalar_data;

  vinsn_tracker tracker0 (
    .clk_i, .rst_ni, .issue_i (issue), .issue_vfu_i (vfu_of(req_op_i)),
    .done_alu_i (pe_done[PeAlu]), .done_load_i (pe_done[PeLoad]),
    .done_store_i (pe_done[PeStore]), .running_o (running), .next_id_o (next_id),
    .full_o (full), .idle_o (idle_o), .load_busy_o (load_busy), .store_busy_o (store_busy)
  );

  hazard_scoreboard scoreboard0 (
    .clk_i, .rst_ni, .issue_i (issue), .id_i (next_id), .op_i (req_op_i),
    .vs1_i (req_vs1_i), .vs2_i (req_vs2_i), .vd_i (req_vd_i),
    .running_i (running), .hazard_o (hazard)
  );

  // Unit answers are zero when idle, so a plain OR merges them
  issue_fsm fsm0 (
    .clk_i, .rst_ni, .req_valid_i, .req_op_i, .req_vl_i, .req_scalar_i,
    .req_ready_o, .resp_valid_o, .resp_error_o, .resp_data_o,
    .pe_ready_i (pe_ready), .next_id_i (next_id), .full_i (full),
    .load_busy_i (load_busy), .store_busy_i (store_busy), .hazard_i (hazard),
    .addr_ack_i (|addr_ack), .addr_err_i (|addr_err), .scalar_valid_i (|scalar_valid),
    .scalar_data_i (scalar_data[PeAlu] | scalar_data[PeLoad] | scalar_data[PeStore]),
    .issue_o (issue), .pe_valid_o (pe_valid), .pe_id_o (pe_id), .pe_op_o (pe_op),
    .pe_vfu_o (pe_vfu), .pe_vl_o (pe_vl), .pe_scalar_o (pe_scalar), .pe_haz_o (pe_haz)
  );

  exec_unit #(.Unit (VFU_Alu), .BaseLat (BaseLatAlu)) alu0 (
    .clk_i, .rst_ni, .pe_valid_i (pe_valid), .pe_id_i (pe_id), .pe_op_i (pe_op),
    .pe_vfu_i (pe_vfu), .pe_vl_i (pe_vl), .pe_scalar_i (pe_scalar), .pe_haz_i (pe_haz),
    .running_i (running), .pe_ready_o (pe_ready[PeAlu]), .done_o (pe_done[PeAlu]),
    .addr_ack_o (addr_ack[PeAlu]), .addr_err_o (addr_err[PeAlu]),
    .scalar_valid_o (scalar_valid[PeAlu]), .scalar_data_o (scalar_data[PeAlu])
  );

  exec_unit #(.Unit (VFU_Load), .BaseLat (BaseLatMem)) load0 (
    .clk_i, .rst_ni, .pe_valid_i (pe_valid), .pe_id_i (pe_id), .pe_op_i (pe_op),
    .pe_vfu_i (pe_vfu), .pe_vl_i (pe_vl), .pe_scalar_i (pe_scalar), .pe_haz_i (pe_haz),
    .running_i (running), .pe_ready_o (pe_ready[PeLoad]), .done_o (pe_done[PeLoad]),
    .addr_ack_o (addr_ack[PeLoad]), .addr_err_o (addr_err[PeLoad]),
    .scalar_valid_o (scalar_valid[PeLoad]), .scalar_data_o (scalar_data[PeLoad])
  );

  exec_unit #(.Unit (VFU_Store), .BaseLat (BaseLatMem)) store0 (
    .clk_i, .rst_ni, .pe_valid_i (pe_valid), .pe_id_i (pe_id), .pe_op_i (pe_op),
    .pe_vfu_i (pe_vfu), .pe_vl_i (pe_vl), .pe_scalar_i (pe_scalar), .pe_haz_i (pe_haz),
    .running_i (running), .pe_ready_o (pe_ready[PeStore]), .done_o (pe_done[PeStore]),
    .addr_ack_o (addr_ack[PeStore]), .addr_err_o (addr_err[PeStore]),
    .scalar_valid_o (scalar_valid[PeStore]), .scalar_data_o (scalar_data[PeStore])
  );

endmodule

`default_nettype wire
